/* source/trace_pkg.sv */
//************************************************
// trace capture shared types and sizes.
// record kind encoding, memory depth, lane mask.
//************************************************

package trace_pkg;

  // field widths.
  localparam int WORD_W  = 32;
  localparam int MASK_W  = 4;
  localparam int INDEX_W = 6;
  localparam int COUNT_W = INDEX_W + 1; // holds 0 to 64.
  localparam int DROP_W  = 16;

  // memwrite slot carries strobes above the data word.
  localparam int MEM_PAYLOAD_W = MASK_W + WORD_W;

  // trace memory entries.
  localparam int TRACE_DEPTH = 1 << INDEX_W;

  // exec and regwrite records cover the whole word.
  localparam logic [MASK_W-1:0] FULL_MASK = {MASK_W{1'b1}};

  typedef logic [WORD_W-1:0]  word_t;        // address or data word.
  typedef logic [MASK_W-1:0]  mask_t;        // byte lanes of a record.
  typedef logic [INDEX_W-1:0] trace_index_t; // memory slot number.
  typedef logic [COUNT_W-1:0] trace_count_t; // valid entries.
  typedef logic [DROP_W-1:0]  drop_count_t;  // saturating drop count.

  // record kind, stored with every entry.
  typedef enum logic [1:0] {
    kind_exec     = 2'd0,
    kind_regwrite = 2'd1,
    kind_memwrite = 2'd2
  } trace_kind_t;

endpackage

/* source/event_slot.sv */
//************************************************
// one-entry holding register for an event stream.
// pending flag toward the arbiter, drop counter.
//************************************************

`timescale 1ns/100ps

module event_slot #(
  parameter trace_pkg::trace_kind_t KIND = trace_pkg::kind_exec,
  parameter int PAYLOAD_W = trace_pkg::WORD_W
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fire,
  input  trace_pkg::word_t       event_addr,
  input  logic [PAYLOAD_W-1:0]   event_payload,
  input  logic                   grant,
  output logic                   pending,
  output trace_pkg::word_t       slot_addr,
  output logic [PAYLOAD_W-1:0]   slot_payload,
  output trace_pkg::drop_count_t drops
);

  logic take;    // new event lands in the register.
  logic refuse;  // event lost, old record still waiting.

  // memwrite records need the strobe lanes above the data.
  if (KIND == trace_pkg::kind_memwrite) begin : g_mem_check
    if (PAYLOAD_W != trace_pkg::MEM_PAYLOAD_W) begin : g_bad_width
      $error("memwrite slot needs %0d payload bits", trace_pkg::MEM_PAYLOAD_W);
    end
  end else begin : g_word_check
    if (PAYLOAD_W != trace_pkg::WORD_W) begin : g_bad_width
      $error("exec and regwrite slots carry one word");
    end
  end

  assign take   = fire && (!pending || grant); // empty, or draining this edge.
  assign refuse = fire && pending && !grant;

  // control state.
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
      drops   <= '0;
    end else begin
      if (take) begin
        pending <= 1'b1;
      end else if (grant) begin
        pending <= 1'b0; // record went to memory.
      end
      if (refuse && (drops != '1)) begin
        drops <= drops + 1'b1; // stops at all ones.
      end
    end
  end

  // payload, only loaded when accepted.
  always_ff @(posedge clock) begin
    if (take) begin
      slot_addr    <= event_addr;
      slot_payload <= event_payload;
    end
  end

endmodule

/* source/trace_arbiter.sv */
//************************************************
// fixed-priority grant over the three slots.
// record assembly, write pointer, fill status.
//************************************************

`timescale 1ns/100ps

module trace_arbiter (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               exec_pending,
  input  trace_pkg::word_t                   exec_addr,
  input  trace_pkg::word_t                   exec_payload,
  input  logic                               reg_pending,
  input  trace_pkg::word_t                   reg_addr,
  input  trace_pkg::word_t                   reg_payload,
  input  logic                               mem_pending,
  input  trace_pkg::word_t                   mem_addr,
  input  logic [trace_pkg::MEM_PAYLOAD_W-1:0] mem_payload,
  output logic                               exec_grant,
  output logic                               reg_grant,
  output logic                               mem_grant,
  output logic                               write_enable,
  output trace_pkg::trace_index_t            write_index,
  output trace_pkg::trace_kind_t             write_kind,
  output trace_pkg::mask_t                   write_mask,
  output trace_pkg::word_t                   write_addr,
  output trace_pkg::word_t                   write_data,
  output trace_pkg::trace_count_t            entry_count,
  output logic                               wrapped
);

  trace_pkg::trace_index_t wr_ptr; // next slot to fill.

  // memwrite wins, then regwrite, then exec.
  assign mem_grant    = mem_pending;
  assign reg_grant    = reg_pending && !mem_pending;
  assign exec_grant   = exec_pending && !mem_pending && !reg_pending;
  assign write_enable = mem_pending || reg_pending || exec_pending;
  assign write_index  = wr_ptr;

  // record fields from the winner.
  always_comb begin
    write_kind = trace_pkg::kind_exec;
    write_mask = trace_pkg::FULL_MASK;
    write_addr = exec_addr;
    write_data = exec_payload;
    if (mem_grant) begin
      write_kind = trace_pkg::kind_memwrite;
      write_mask = mem_payload[trace_pkg::MEM_PAYLOAD_W-1 -: trace_pkg::MASK_W]; // mstrb.
      write_addr = mem_addr;
      write_data = mem_payload[trace_pkg::WORD_W-1:0];
    end else if (reg_grant) begin
      write_kind = trace_pkg::kind_regwrite;
      write_addr = reg_addr;
      write_data = reg_payload;
    end
  end

  // circular pointer and fill tracking.
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr      <= '0;
      entry_count <= '0;
      wrapped     <= 1'b0;
    end else if (write_enable) begin
      wr_ptr <= wr_ptr + 1'b1; // wraps at 64.
      if (entry_count == trace_pkg::trace_count_t'(trace_pkg::TRACE_DEPTH)) begin
        wrapped <= 1'b1; // oldest entry overwritten, sticky.
      end else begin
        entry_count <= entry_count + 1'b1;
      end
    end
  end

endmodule

/* source/trace_buffer.sv */
//************************************************
// trace record memory, 64 entries.
// one write port, one registered read port.
//************************************************

`timescale 1ns/100ps

module trace_buffer (
  input  logic                    clock,
  input  logic                    write_enable,
  input  trace_pkg::trace_index_t write_index,
  input  trace_pkg::trace_kind_t  write_kind,
  input  trace_pkg::mask_t        write_mask,
  input  trace_pkg::word_t        write_addr,
  input  trace_pkg::word_t        write_data,
  input  trace_pkg::trace_index_t read_index,
  output trace_pkg::trace_kind_t  read_kind,
  output trace_pkg::mask_t        read_mask,
  output trace_pkg::word_t        read_addr,
  output trace_pkg::word_t        read_data
);

  // one array per field, same index.
  trace_pkg::trace_kind_t kind_mem [trace_pkg::TRACE_DEPTH];
  trace_pkg::mask_t       mask_mem [trace_pkg::TRACE_DEPTH];
  trace_pkg::word_t       addr_mem [trace_pkg::TRACE_DEPTH];
  trace_pkg::word_t       data_mem [trace_pkg::TRACE_DEPTH];

  // write at the granted edge.
  always_ff @(posedge clock) begin
    if (write_enable) begin
      kind_mem[write_index] <= write_kind;
      mask_mem[write_index] <= write_mask;
      addr_mem[write_index] <= write_addr;
      data_mem[write_index] <= write_data;
    end
  end

  // readout one cycle after read_index is sampled.
  always_ff @(posedge clock) begin
    read_kind <= kind_mem[read_index]; // old contents on a same-edge write.
    read_mask <= mask_mem[read_index];
    read_addr <= addr_mem[read_index];
    read_data <= data_mem[read_index];
  end

endmodule

/* source/trace_capture.sv */
//************************************************
// trace capture top level.
// core strobes into three slots, arbiter, memory.
//************************************************

`timescale 1ns/100ps

module trace_capture (
  input  logic                    clock,
  input  logic                    reset,
  input  trace_pkg::word_t        addr,       // executed pc.
  input  trace_pkg::word_t        instr,
  input  logic                    ivalid,
  input  trace_pkg::word_t        raddr,      // written register.
  input  trace_pkg::word_t        rdata,
  input  logic                    rwrite,
  input  trace_pkg::word_t        maddr,
  input  trace_pkg::word_t        mdata,
  input  trace_pkg::mask_t        mstrb,
  input  logic                    mwrite,
  input  logic                    mvalid,
  input  trace_pkg::trace_index_t read_index,
  output trace_pkg::trace_kind_t  read_kind,
  output trace_pkg::mask_t        read_mask,
  output trace_pkg::word_t        read_addr,
  output trace_pkg::word_t        read_data,
  output trace_pkg::trace_count_t entry_count,
  output logic                    wrapped,
  output trace_pkg::drop_count_t  exec_drops,
  output trace_pkg::drop_count_t  reg_drops,
  output trace_pkg::drop_count_t  mem_drops
);

  logic mem_fire; // only real stores are traced.

  logic                               exec_pending, reg_pending, mem_pending;
  logic                               exec_grant, reg_grant, mem_grant;
  trace_pkg::word_t                   exec_addr, reg_addr, mem_addr;
  trace_pkg::word_t                   exec_payload, reg_payload;
  logic [trace_pkg::MEM_PAYLOAD_W-1:0] mem_payload;

  logic                    write_enable;
  trace_pkg::trace_index_t write_index;
  trace_pkg::trace_kind_t  write_kind;
  trace_pkg::mask_t        write_mask;
  trace_pkg::word_t        write_addr;
  trace_pkg::word_t        write_data;

  assign mem_fire = mvalid && mwrite;

  event_slot #(.KIND(trace_pkg::kind_exec), .PAYLOAD_W(trace_pkg::WORD_W)) u_exec_slot (
    .clock(clock), .reset(reset), .fire(ivalid),
    .event_addr(addr), .event_payload(instr), .grant(exec_grant),
    .pending(exec_pending), .slot_addr(exec_addr), .slot_payload(exec_payload),
    .drops(exec_drops)
  );

  event_slot #(.KIND(trace_pkg::kind_regwrite), .PAYLOAD_W(trace_pkg::WORD_W)) u_reg_slot (
    .clock(clock), .reset(reset), .fire(rwrite),
    .event_addr(raddr), .event_payload(rdata), .grant(reg_grant),
    .pending(reg_pending), .slot_addr(reg_addr), .slot_payload(reg_payload),
    .drops(reg_drops)
  );

  // strobes ride above the store data.
  event_slot #(
    .KIND(trace_pkg::kind_memwrite),
    .PAYLOAD_W(trace_pkg::MEM_PAYLOAD_W)
  ) u_mem_slot (
    .clock(clock), .reset(reset), .fire(mem_fire),
    .event_addr(maddr), .event_payload({mstrb, mdata}), .grant(mem_grant),
    .pending(mem_pending), .slot_addr(mem_addr), .slot_payload(mem_payload),
    .drops(mem_drops)
  );

  trace_arbiter u_arbiter (
    .clock(clock), .reset(reset),
    .exec_pending(exec_pending), .exec_addr(exec_addr), .exec_payload(exec_payload),
    .reg_pending(reg_pending), .reg_addr(reg_addr), .reg_payload(reg_payload),
    .mem_pending(mem_pending), .mem_addr(mem_addr), .mem_payload(mem_payload),
    .exec_grant(exec_grant), .reg_grant(reg_grant), .mem_grant(mem_grant),
    .write_enable(write_enable), .write_index(write_index),
    .write_kind(write_kind), .write_mask(write_mask),
    .write_addr(write_addr), .write_data(write_data),
    .entry_count(entry_count), .wrapped(wrapped)
  );

  trace_buffer u_buffer (
    .clock(clock),
    .write_enable(write_enable), .write_index(write_index),
    .write_kind(write_kind), .write_mask(write_mask),
    .write_addr(write_addr), .write_data(write_data),
    .read_index(read_index),
    .read_kind(read_kind), .read_mask(read_mask),
    .read_addr(read_addr), .read_data(read_data)
  );

endmodule

/* sim/trace_capture_asserts.sv */
//************************************************
// arbiter properties, bound into trace_arbiter.
//************************************************

`timescale 1ns/100ps

module trace_capture_asserts (
  input logic clock,
  input logic reset,
  input logic exec_pending,
  input logic reg_pending,
  input logic mem_pending,
  input logic exec_grant,
  input logic reg_grant,
  input logic mem_grant,
  input logic write_enable,
  input logic wrapped
);

  grant_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0({exec_grant, reg_grant, mem_grant}))
    else $error("more than one slot granted");

  grant_to_pending: assert property (@(posedge clock) disable iff (reset)
    (!exec_grant || exec_pending) && (!reg_grant || reg_pending) && (!mem_grant || mem_pending))
    else $error("grant given to an empty slot");

  write_on_grant: assert property (@(posedge clock) disable iff (reset)
    write_enable == (exec_grant || reg_grant || mem_grant))
    else $error("write_enable does not follow the grants");

  // sticky until reset.
  wrapped_sticky: assert property (@(posedge clock) $fell(wrapped) |-> $past(reset))
    else $error("wrapped fell without reset");

endmodule

bind trace_arbiter trace_capture_asserts u_asserts (
  .clock(clock), .reset(reset),
  .exec_pending(exec_pending), .reg_pending(reg_pending), .mem_pending(mem_pending),
  .exec_grant(exec_grant), .reg_grant(reg_grant), .mem_grant(mem_grant),
  .write_enable(write_enable), .wrapped(wrapped)
);

/* sim/trace_capture_tb.sv */
//************************************************
// testbench for the trace capture unit.
// event table, cycle model of slots and arbiter,
// per-cycle status checks and memory readout.
//************************************************

`timescale 1ns/100ps

module trace_capture_tb;

  logic clock, reset;
  trace_pkg::word_t addr, instr, raddr, rdata, maddr, mdata;
  logic ivalid, rwrite, mwrite, mvalid;
  trace_pkg::mask_t mstrb;
  trace_pkg::trace_index_t read_index;
  trace_pkg::trace_kind_t read_kind;
  trace_pkg::mask_t read_mask;
  trace_pkg::word_t read_addr, read_data;
  trace_pkg::trace_count_t entry_count;
  logic wrapped;
  trace_pkg::drop_count_t exec_drops, reg_drops, mem_drops;

  // one table row, strobes are ivalid rwrite mvalid mwrite.
  typedef struct packed {
    logic rst_before;
    logic check_after;
    logic [3:0] strobes;
    logic rand_data;
    int idle;
    int reps;
    trace_pkg::word_t addr;
    trace_pkg::word_t data;
    trace_pkg::mask_t strb;
  } row_t;

  // rst chk strobes rnd idle reps addr data strb.
  row_t rows [11] = '{
    '{1'b0, 1'b0, 4'b1000, 1'b0, 0, 1, 32'h0000_1000, 32'h0000_0013, 4'hf},   // lone exec.
    '{1'b0, 1'b0, 4'b0100, 1'b1, 2, 1, 32'h0000_0005, 32'h0, 4'hf},           // lone regwrite.
    '{1'b0, 1'b0, 4'b0011, 1'b0, 2, 1, 32'h2000_0040, 32'hcafe_f00d, 4'b0011}, // lone store.
    '{1'b0, 1'b0, 4'b0010, 1'b0, 2, 1, 32'h2000_0080, 32'h1111_2222, 4'hf},   // no mwrite.
    '{1'b0, 1'b0, 4'b0001, 1'b0, 2, 1, 32'h2000_00c0, 32'h3333_4444, 4'hf},   // no mvalid.
    '{1'b0, 1'b0, 4'b1111, 1'b0, 3, 1, 32'h0000_2000, 32'h0bad_beef, 4'b1100}, // all at once.
    '{1'b0, 1'b0, 4'b1111, 1'b1, 3, 6, 32'h0000_3000, 32'h0, 4'b1010},
    '{1'b0, 1'b1, 4'b1011, 1'b1, 2, 5, 32'h0000_4000, 32'h0, 4'b0110},        // exec starved.
    '{1'b1, 1'b1, 4'b1000, 1'b1, 0, 70, 32'h0001_0000, 32'h0, 4'hf},          // wraps memory.
    '{1'b0, 1'b1, 4'b1111, 1'b1, 1, 12, 32'h0002_0000, 32'h0, 4'b1001},
    '{1'b1, 1'b1, 4'b0100, 1'b0, 0, 1, 32'h0000_001f, 32'h7777_0001, 4'hf}    // after reset.
  };

  // model state, slot 0 exec, 1 regwrite, 2 memwrite.
  logic [2:0] m_pend;
  trace_pkg::word_t m_addr [3];
  logic [35:0] m_pay [3];             // strobes above data.
  trace_pkg::drop_count_t m_drops [3];
  trace_pkg::trace_index_t m_wptr;
  trace_pkg::trace_count_t m_count;
  logic m_wrapped;
  logic [69:0] exp_q [$];              // kind, mask, addr, data; newest 64.
  logic [31:0] lfsr;
  logic passed, failed;

  trace_capture u_dut (.*);

  always #2 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1.
  endfunction

  function automatic trace_pkg::word_t random_word();
    trace_pkg::word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]}; // one step per bit.
    end
    return w;
  endfunction

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    failed = 1'b1;
    $fatal(1, "stopping at first failure");
  endtask

  task automatic model_reset();
    m_pend = '0;
    m_drops = '{default: '0};
    m_wptr = '0;
    m_count = '0;
    m_wrapped = 1'b0;
    exp_q.delete();
  endtask

  // one rising edge, grant from old pending, then capture.
  task automatic model_step();
    logic [2:0] fire;
    trace_pkg::word_t new_addr [3];
    logic [35:0] new_pay [3];
    logic [69:0] rec;
    int g;
    fire = {mvalid && mwrite, rwrite, ivalid};
    new_addr = '{addr, raddr, maddr};
    new_pay = '{{4'h0, instr}, {4'h0, rdata}, {mstrb, mdata}};
    g = m_pend[2] ? 2 : m_pend[1] ? 1 : m_pend[0] ? 0 : -1;
    if (g >= 0) begin
      case (g)
        2: rec = {trace_pkg::kind_memwrite, m_pay[2][35:32], m_addr[2], m_pay[2][31:0]};
        1: rec = {trace_pkg::kind_regwrite, trace_pkg::FULL_MASK, m_addr[1], m_pay[1][31:0]};
        default: rec = {trace_pkg::kind_exec, trace_pkg::FULL_MASK, m_addr[0], m_pay[0][31:0]};
      endcase
      exp_q.push_back(rec);
      if (exp_q.size() > trace_pkg::TRACE_DEPTH) void'(exp_q.pop_front()); // overwritten.
      m_wptr = m_wptr + 1'b1;
      if (m_count == 7'd64) m_wrapped = 1'b1;
      else m_count = m_count + 1'b1;
    end
    for (int s = 0; s < 3; s++) begin
      if (fire[s] && (!m_pend[s] || g == s)) begin
        m_pend[s] = 1'b1;
        m_addr[s] = new_addr[s];
        m_pay[s] = new_pay[s];
      end else if (fire[s]) begin
        if (m_drops[s] != '1) m_drops[s] = m_drops[s] + 1'b1; // saturates.
      end else if (g == s) begin
        m_pend[s] = 1'b0;
      end
    end
  endtask

  task automatic check_status();
    assert (entry_count == m_count) else stop_on_failure($sformatf(
      "[ERROR] %0t entry_count %0d, expected %0d", $time, entry_count, m_count));
    assert (wrapped == m_wrapped) else stop_on_failure($sformatf(
      "[ERROR] %0t wrapped %b, expected %b", $time, wrapped, m_wrapped));
    assert ({exec_drops, reg_drops, mem_drops} == {m_drops[0], m_drops[1], m_drops[2]})
      else stop_on_failure($sformatf("[ERROR] %0t drops %0d/%0d/%0d, expected %0d/%0d/%0d",
        $time, exec_drops, reg_drops, mem_drops, m_drops[0], m_drops[1], m_drops[2]));
  endtask

  task automatic set_inputs(input logic [3:0] st, input trace_pkg::word_t a,
                            input trace_pkg::word_t d, input trace_pkg::mask_t s);
    {ivalid, rwrite, mvalid, mwrite} = st;
    addr = a;
    instr = d;
    raddr = a + 1;               // distinct per stream.
    rdata = ~d;
    maddr = a + 2;
    mdata = d ^ 32'h5a5a_5a5a;
    mstrb = s;
  endtask

  // drive at the falling edge, check after the next rising one.
  task automatic drive_cycle(input logic [3:0] st, input trace_pkg::word_t a,
                             input trace_pkg::word_t d, input trace_pkg::mask_t s);
    set_inputs(st, a, d, s);
    model_step();
    @(negedge clock);
    check_status();
  endtask

  task automatic idle_cycle();
    drive_cycle(4'b0000, '0, '0, '0);
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    set_inputs(4'b0000, '0, '0, '0);
    model_reset();
    repeat (2) @(negedge clock);
    reset = 1'b0;
    check_status(); // counts and drops cleared.
  endtask

  task automatic drain();
    int stable;
    trace_pkg::trace_count_t last;
    stable = 0;
    last = entry_count;
    while (m_pend != '0) begin
      idle_cycle();
      if (entry_count != last) begin
        last = entry_count;
        stable = 0;
      end else begin
        stable++;
      end
      if (stable >= 200) stop_on_failure("timeout: records still pending, entry_count stuck");
    end
  endtask

  // oldest record sits at the write pointer once wrapped.
  task automatic read_all();
    trace_pkg::trace_index_t start;
    trace_pkg::trace_index_t idx;
    logic [69:0] got;
    start = m_wrapped ? m_wptr : '0;
    for (int k = 0; k < exp_q.size(); k++) begin
      idx = trace_pkg::trace_index_t'(start + k);
      read_index = idx;
      idle_cycle();                // one cycle read latency.
      got = {read_kind, read_mask, read_addr, read_data};
      assert (got == exp_q[k]) else stop_on_failure($sformatf(
        "[ERROR] %0t entry %0d holds %h, expected %h", $time, idx, got, exp_q[k]));
    end
  endtask

  task automatic apply_row(input row_t row);
    trace_pkg::word_t d;
    if (row.rst_before) apply_reset();
    repeat (row.idle) idle_cycle();
    for (int k = 0; k < row.reps; k++) begin
      d = row.rand_data ? random_word() : row.data + k;
      drive_cycle(row.strobes, row.addr + 4 * k, d, row.strb);
    end
    if (row.check_after) begin
      drain();
      read_all();
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    read_index = '0;
    set_inputs(4'b0000, '0, '0, '0);
    lfsr = 32'h2c273ae5;
    passed = 1'b0;
    failed = 1'b0;
    apply_reset();
    foreach (rows[r]) apply_row(rows[r]);
    passed = 1'b1;
    $display("*** TEST PASSED ***");
    $finish;
  end

  // run ended early, e.g. by a bound assertion.
  final begin
    if (!passed && !failed) $display("*** TEST FAILED ***");
  end

endmodule

/* trace_capture.f */
source/trace_pkg.sv
source/event_slot.sv
source/trace_arbiter.sv
source/trace_buffer.sv
source/trace_capture.sv
sim/trace_capture_asserts.sv
sim/trace_capture_tb.sv

/* Makefile */
# Verilator flow for the trace capture unit.
TOP = trace_capture_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f trace_capture.f --top-module $(TOP)

# a $fatal in the run gives a failing exit status.
sim:
	verilator --binary --timing --assert -f trace_capture.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
